//--- all.f
hdl/branch_pkg.sv
hdl/branch_resolution_unit.sv
hdl/branch_flag_stage.sv
hdl/branch_resolve_stage.sv
hdl/branch_redirect_stage.sv
hdl/branch_exec_top.sv
testbench/branch_exec_tb.sv

//--- hdl/branch_exec_top.sv
`timescale 1ns/1ps

module branch_exec_top #(
    parameter int XLEN = branch_pkg::XLEN_DEFAULT
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,

    // Branch item in
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  logic [XLEN-1:0]        rs1_i,
    input  logic [XLEN-1:0]        rs2_i,
    input  logic [XLEN-1:0]        pc_i,
    input  logic [XLEN-1:0]        imm_i,
    input  logic [2:0]             funct3_i,
    input  branch_pkg::branch_op_e branch_op_i,
    input  logic                   jalr_i,
    input  logic                   pred_taken_i,
    input  logic [XLEN-1:0]        pred_target_i,

    // Result out
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output logic                   taken_o,
    output logic                   mispredict_o,
    output logic [XLEN-1:0]        redirect_pc_o,
    output logic [XLEN-1:0]        link_addr_o
);

    // Flag stage to resolve stage
    logic                   s1_valid;
    logic                   s1_ready;
    logic                   s1_neg;
    logic                   s1_zero;
    logic                   s1_carry;
    logic                   s1_v;
    logic [2:0]             s1_funct3;
    branch_pkg::branch_op_e s1_op;
    logic                   s1_jalr;
    logic [XLEN-1:0]        s1_pc;
    logic [XLEN-1:0]        s1_rs1;
    logic [XLEN-1:0]        s1_imm;
    logic                   s1_pred_taken;
    logic [XLEN-1:0]        s1_pred_target;

    // Resolve stage to redirect stage
    logic                   s2_valid;
    logic                   s2_ready;
    logic                   s2_taken;
    logic [XLEN-1:0]        s2_target;
    logic [XLEN-1:0]        s2_pc;
    logic                   s2_pred_taken;
    logic [XLEN-1:0]        s2_pred_target;
    branch_pkg::branch_op_e s2_op;

    branch_flag_stage #(.XLEN(XLEN)) u_flag (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .pc_i          (pc_i),
        .imm_i         (imm_i),
        .funct3_i      (funct3_i),
        .branch_op_i   (branch_op_i),
        .jalr_i        (jalr_i),
        .pred_taken_i  (pred_taken_i),
        .pred_target_i (pred_target_i),
        .out_valid_o   (s1_valid),
        .out_ready_i   (s1_ready),
        .neg_o         (s1_neg),
        .zero_o        (s1_zero),
        .carry_o       (s1_carry),
        .v_o           (s1_v),
        .funct3_o      (s1_funct3),
        .branch_op_o   (s1_op),
        .jalr_o        (s1_jalr),
        .pc_o          (s1_pc),
        .rs1_o         (s1_rs1),
        .imm_o         (s1_imm),
        .pred_taken_o  (s1_pred_taken),
        .pred_target_o (s1_pred_target)
    );

    branch_resolve_stage #(.XLEN(XLEN)) u_resolve (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .in_valid_i    (s1_valid),
        .in_ready_o    (s1_ready),
        .neg_i         (s1_neg),
        .zero_i        (s1_zero),
        .carry_i       (s1_carry),
        .v_i           (s1_v),
        .funct3_i      (s1_funct3),
        .branch_op_i   (s1_op),
        .jalr_i        (s1_jalr),
        .pc_i          (s1_pc),
        .rs1_i         (s1_rs1),
        .imm_i         (s1_imm),
        .pred_taken_i  (s1_pred_taken),
        .pred_target_i (s1_pred_target),
        .out_valid_o   (s2_valid),
        .out_ready_i   (s2_ready),
        .taken_o       (s2_taken),
        .target_o      (s2_target),
        .pc_o          (s2_pc),
        .pred_taken_o  (s2_pred_taken),
        .pred_target_o (s2_pred_target),
        .branch_op_o   (s2_op)
    );

    branch_redirect_stage #(.XLEN(XLEN)) u_redirect (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .in_valid_i    (s2_valid),
        .in_ready_o    (s2_ready),
        .taken_i       (s2_taken),
        .target_i      (s2_target),
        .pc_i          (s2_pc),
        .pred_taken_i  (s2_pred_taken),
        .pred_target_i (s2_pred_target),
        .branch_op_i   (s2_op),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .taken_o       (taken_o),
        .mispredict_o  (mispredict_o),
        .redirect_pc_o (redirect_pc_o),
        .link_addr_o   (link_addr_o)
    );

endmodule

//--- hdl/branch_flag_stage.sv
`timescale 1ns/1ps

module branch_flag_stage #(
    parameter int XLEN = branch_pkg::XLEN_DEFAULT
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,

    // Upstream handshake
    input  logic                   in_valid_i,
    output logic                   in_ready_o,

    // Branch fields from decode
    input  logic [XLEN-1:0]        rs1_i,
    input  logic [XLEN-1:0]        rs2_i,
    input  logic [XLEN-1:0]        pc_i,
    input  logic [XLEN-1:0]        imm_i,
    input  logic [2:0]             funct3_i,
    input  branch_pkg::branch_op_e branch_op_i,
    input  logic                   jalr_i,
    input  logic                   pred_taken_i,   // Fetch prediction
    input  logic [XLEN-1:0]        pred_target_i,

    // Downstream handshake
    output logic                   out_valid_o,
    input  logic                   out_ready_i,

    // Registered flags
    output logic                   neg_o,
    output logic                   zero_o,
    output logic                   carry_o,
    output logic                   v_o,

    // Registered passthrough
    output logic [2:0]             funct3_o,
    output branch_pkg::branch_op_e branch_op_o,
    output logic                   jalr_o,
    output logic [XLEN-1:0]        pc_o,
    output logic [XLEN-1:0]        rs1_o,
    output logic [XLEN-1:0]        imm_o,
    output logic                   pred_taken_o,
    output logic [XLEN-1:0]        pred_target_o
);

    logic [XLEN:0] diff;   // rs1 - rs2, carry-out in MSB
    logic          valid_q;
    logic          load;   // Input transfer this cycle

    // Subtract as rs1 + ~rs2 + 1 so the top bit is the no-borrow carry
    assign diff = {1'b0, rs1_i} + {1'b0, ~rs2_i} + {{XLEN{1'b0}}, 1'b1};

    assign in_ready_o  = !valid_q || out_ready_i; // Empty or draining
    assign out_valid_o = valid_q;
    assign load        = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0; // Item left, nothing new
        end
    end

    // Payload only moves on a transfer
    always_ff @(posedge clk_i) begin
        if (load) begin
            neg_o         <= diff[XLEN-1];
            zero_o        <= (diff[XLEN-1:0] == '0);
            carry_o       <= diff[XLEN];
            // Operand signs differ and result sign flips from rs1
            v_o           <= (rs1_i[XLEN-1] != rs2_i[XLEN-1]) &&
                             (diff[XLEN-1] != rs1_i[XLEN-1]);
            funct3_o      <= funct3_i;
            branch_op_o   <= branch_op_i;
            jalr_o        <= jalr_i;
            pc_o          <= pc_i;
            rs1_o         <= rs1_i;
            imm_o         <= imm_i;
            pred_taken_o  <= pred_taken_i;
            pred_target_o <= pred_target_i;
        end
    end

    // Stalled item stays put until resolve stage takes it
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o &&
            $stable({neg_o, zero_o, carry_o, v_o, funct3_o, branch_op_o, jalr_o}) &&
            $stable({pc_o, rs1_o, imm_o, pred_taken_o, pred_target_o})))
    else $error("flag stage output changed under back-pressure");

endmodule

//--- hdl/branch_pkg.sv
package branch_pkg;

    // Default datapath width for RV32
    parameter int XLEN_DEFAULT = 32;

    // Branch class from decode
    typedef enum logic [1:0] {
        BR_NONE = 2'b00, // Not a control transfer
        BR_JUMP = 2'b01, // JAL and JALR
        BR_COND = 2'b11  // B-type compare and branch
    } branch_op_e;
    // Code 2'b10 is unused

    // B-type conditions as encoded in funct3
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_cond_e;
    // 3'b010 and 3'b011 have no branch meaning

endpackage

//--- hdl/branch_redirect_stage.sv
`timescale 1ns/1ps

module branch_redirect_stage #(
    parameter int XLEN = branch_pkg::XLEN_DEFAULT
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,

    // Upstream handshake
    input  logic                   in_valid_i,
    output logic                   in_ready_o,

    // Resolved branch from stage two
    input  logic                   taken_i,
    input  logic [XLEN-1:0]        target_i,
    input  logic [XLEN-1:0]        pc_i,
    input  logic                   pred_taken_i,
    input  logic [XLEN-1:0]        pred_target_i,
    input  branch_pkg::branch_op_e branch_op_i,

    // Downstream handshake
    output logic                   out_valid_o,
    input  logic                   out_ready_i,

    // Results for fetch and writeback
    output logic                   taken_o,
    output logic                   mispredict_o,
    output logic [XLEN-1:0]        redirect_pc_o,
    output logic [XLEN-1:0]        link_addr_o
);

    import branch_pkg::*;

    logic            valid_q;
    logic            mispredict_q;
    logic            load;
    logic [XLEN-1:0] pc_plus4;      // Fall-through and link
    logic            dir_wrong;     // Direction missed
    logic            tgt_wrong;     // Right direction, wrong target
    logic            mispredict_d;

    assign pc_plus4     = pc_i + {{(XLEN-3){1'b0}}, 3'd4};
    assign dir_wrong    = taken_i != pred_taken_i;
    assign tgt_wrong    = taken_i && pred_taken_i && (target_i != pred_target_i);
    assign mispredict_d = dir_wrong || tgt_wrong;

    assign in_ready_o   = !valid_q || out_ready_i;
    assign out_valid_o  = valid_q;
    assign mispredict_o = mispredict_q;
    assign load         = in_valid_i && in_ready_o;

    // Valid and mispredict are control, both cleared on drain
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q      <= 1'b0;
            mispredict_q <= 1'b0;
        end else if (load) begin
            valid_q      <= 1'b1;
            mispredict_q <= mispredict_d;
        end else if (out_ready_i) begin
            valid_q      <= 1'b0;
            mispredict_q <= 1'b0;   // No stale flush request
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            taken_o       <= taken_i;
            redirect_pc_o <= taken_i ? target_i : pc_plus4;
            link_addr_o   <= pc_plus4;
        end
    end

    // Flush request only alongside a valid result
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !out_valid_o |-> !mispredict_o)
    else $error("mispredict raised with no valid output");

endmodule

//--- hdl/branch_resolution_unit.sv
`timescale 1ns/1ps

module branch_resolution_unit (
    // Decode fields
    input  logic [2:0] funct3_i,
    input  logic [1:0] branch_op_i,

    // Flags of rs1 - rs2
    input  logic       neg_flag_i,
    input  logic       zero_flag_i,
    input  logic       carry_flag_i,
    input  logic       v_flag_i,

    // High means take the branch
    output logic       pc_src_res_o
);

    import branch_pkg::*;

    logic lt_signed; // Signed less-than from the flags

    assign lt_signed = neg_flag_i ^ v_flag_i;

    always_comb begin
        case (branch_op_i)
            BR_NONE: pc_src_res_o = 1'b0; // Plain instruction
            BR_JUMP: pc_src_res_o = 1'b1; // Unconditional
            BR_COND: begin
                // Condition picked by funct3
                case (funct3_i)
                    BEQ:     pc_src_res_o = zero_flag_i;
                    BNE:     pc_src_res_o = !zero_flag_i;
                    BLT:     pc_src_res_o = lt_signed;
                    BGE:     pc_src_res_o = !lt_signed;
                    BLTU:    pc_src_res_o = !carry_flag_i; // Borrow seen
                    BGEU:    pc_src_res_o = carry_flag_i;
                    default: pc_src_res_o = 1'b0;          // Undefined condition
                endcase
            end
            default: pc_src_res_o = 1'b0; // Undefined op falls through
        endcase
    end

    // Unused op encoding must never reach resolution
    always_comb begin
        assert (branch_op_i !== 2'b10)
        else $error("branch_op 2'b10 reached the resolution unit");
    end

endmodule

//--- hdl/branch_resolve_stage.sv
`timescale 1ns/1ps

module branch_resolve_stage #(
    parameter int XLEN = branch_pkg::XLEN_DEFAULT
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,

    // Upstream handshake
    input  logic                   in_valid_i,
    output logic                   in_ready_o,

    // Flags from stage one
    input  logic                   neg_i,
    input  logic                   zero_i,
    input  logic                   carry_i,
    input  logic                   v_i,

    // Branch fields
    input  logic [2:0]             funct3_i,
    input  branch_pkg::branch_op_e branch_op_i,
    input  logic                   jalr_i,
    input  logic [XLEN-1:0]        pc_i,
    input  logic [XLEN-1:0]        rs1_i,
    input  logic [XLEN-1:0]        imm_i,
    input  logic                   pred_taken_i,
    input  logic [XLEN-1:0]        pred_target_i,

    // Downstream handshake
    output logic                   out_valid_o,
    input  logic                   out_ready_i,

    // Resolved branch
    output logic                   taken_o,
    output logic [XLEN-1:0]        target_o,
    output logic [XLEN-1:0]        pc_o,
    output logic                   pred_taken_o,
    output logic [XLEN-1:0]        pred_target_o,
    output branch_pkg::branch_op_e branch_op_o
);

    import branch_pkg::*;

    logic            valid_q;
    logic            load;
    logic            taken_d;   // From resolution unit
    logic [XLEN-1:0] jalr_sum;  // rs1 + imm
    logic [XLEN-1:0] target_d;

    branch_resolution_unit u_bru (
        .funct3_i     (funct3_i),
        .branch_op_i  (branch_op_i),
        .neg_flag_i   (neg_i),
        .zero_flag_i  (zero_i),
        .carry_flag_i (carry_i),
        .v_flag_i     (v_i),
        .pc_src_res_o (taken_d)
    );

    assign jalr_sum = rs1_i + imm_i;
    // JALR drops bit 0, all others are pc relative
    assign target_d = jalr_i ? {jalr_sum[XLEN-1:1], 1'b0} : (pc_i + imm_i);

    assign in_ready_o  = !valid_q || out_ready_i;
    assign out_valid_o = valid_q;
    assign load        = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            taken_o       <= taken_d;
            target_o      <= target_d;
            pc_o          <= pc_i;
            pred_taken_o  <= pred_taken_i;
            pred_target_o <= pred_target_i;
            branch_op_o   <= branch_op_i;
        end
    end

    // Decode should never hand over a conditional with a reserved funct3
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (load && branch_op_i == BR_COND) |-> !(funct3_i inside {3'b010, 3'b011}))
    else $error("undefined funct3 %b on accepted conditional branch", funct3_i);

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the branch execute testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module branch_exec_tb -o branch_exec_sim \
    && ./obj_dir/branch_exec_sim > sim.log 2>&1
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- testbench/branch_exec_tb.sv
`timescale 1ns/1ps

module branch_exec_tb;

    import branch_pkg::*;

    localparam int XLEN       = XLEN_DEFAULT;
    localparam int max_cycles = 3000; // Roughly 1200 used, random phase at half rate dominates

    logic            clk_i = 1'b0;
    logic            arst_n_i;
    logic            in_valid_i;
    logic            in_ready_o;
    logic [XLEN-1:0] rs1_i;
    logic [XLEN-1:0] rs2_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] imm_i;
    logic [2:0]      funct3_i;
    branch_op_e      branch_op_i;
    logic            jalr_i;
    logic            pred_taken_i;
    logic [XLEN-1:0] pred_target_i;
    logic            out_valid_o;
    logic            out_ready_i = 1'b1; // Held high until random phase
    logic            taken_o;
    logic            mispredict_o;
    logic [XLEN-1:0] redirect_pc_o;
    logic [XLEN-1:0] link_addr_o;

    // Reference FIFO of expected results
    logic            exp_taken    [0:1023];
    logic            exp_misp     [0:1023];
    logic [XLEN-1:0] exp_redirect [0:1023];
    logic [XLEN-1:0] exp_link     [0:1023];
    int              exp_test     [0:1023]; // Test id per item
    int              exp_cycle    [0:1023]; // Accept cycle
    logic            exp_lat      [0:1023]; // Latency checked for this item
    logic [9:0]      wr_ptr = 10'd0;
    logic [9:0]      rd_ptr = 10'd0;

    integer          seed = 32'h24f2_cf0b;
    logic            ready_pattern [0:4095];
    logic            ready_random = 1'b0;
    logic            lat_phase = 1'b0;
    int              cur_test = 0;
    int              items_sent = 0;
    int              cycle_cnt = 0;
    logic            in_xfer;
    logic            out_xfer;
    logic            in_taken;      // Expected direction of current input
    logic [XLEN-1:0] in_target;
    logic [XLEN-1:0] in_pc_plus4;

    branch_exec_top #(.XLEN(XLEN)) dut0 (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .pc_i          (pc_i),
        .imm_i         (imm_i),
        .funct3_i      (funct3_i),
        .branch_op_i   (branch_op_i),
        .jalr_i        (jalr_i),
        .pred_taken_i  (pred_taken_i),
        .pred_target_i (pred_target_i),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .taken_o       (taken_o),
        .mispredict_o  (mispredict_o),
        .redirect_pc_o (redirect_pc_o),
        .link_addr_o   (link_addr_o)
    );

    always #10 clk_i = ~clk_i;

    function automatic string test_name(input int id);
        case (id)
            1:       return "cond_directed";
            2:       return "jump_none";
            3:       return "mispredict";
            4:       return "random_backpressure";
            5:       return "latency";
            default: return "unknown";
        endcase
    endfunction

    // Direction straight from the RISC-V compare semantics
    function automatic logic ref_taken(input branch_op_e op, input logic [2:0] f3,
                                       input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic t;
        t = 1'b0;
        if (op == BR_JUMP) begin
            t = 1'b1;
        end else if (op == BR_COND) begin
            case (f3)
                3'b000:  t = (a == b);
                3'b001:  t = (a != b);
                3'b100:  t = ($signed(a) < $signed(b));
                3'b101:  t = ($signed(a) >= $signed(b));
                3'b110:  t = (a < b);
                3'b111:  t = (a >= b);
                default: t = 1'b0; // Reserved codes not taken
            endcase
        end
        return t;
    endfunction

    function automatic logic [XLEN-1:0] ref_target(input logic jalr, input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] pc,
                                                   input logic [XLEN-1:0] imm);
        logic [XLEN-1:0] sum;
        sum = a + imm;
        return jalr ? {sum[XLEN-1:1], 1'b0} : (pc + imm);
    endfunction

    task automatic report_mismatch(input string field, input int test_id,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("mismatch %s %s: expected %h actual %h", test_name(test_id), field,
                 expected, actual);
        $display("tests failed");
        $fatal(1, "value check failed");
    endtask

    task automatic report_failure(input string what);
        $display("error: %s", what);
        $display("tests failed");
        $fatal(1, "protocol check failed");
    endtask

    assign in_xfer     = in_valid_i && in_ready_o;
    assign out_xfer    = out_valid_o && out_ready_i;
    assign in_taken    = ref_taken(branch_op_i, funct3_i, rs1_i, rs2_i);
    assign in_target   = ref_target(jalr_i, rs1_i, pc_i, imm_i);
    assign in_pc_plus4 = pc_i + 32'd4;

    // Push on accept, pop on output transfer
    always @(posedge clk_i) begin
        if (in_xfer) begin
            exp_taken[wr_ptr]    <= in_taken;
            exp_misp[wr_ptr]     <= (in_taken != pred_taken_i) ||
                                    (in_taken && pred_taken_i && in_target != pred_target_i);
            exp_redirect[wr_ptr] <= in_taken ? in_target : in_pc_plus4;
            exp_link[wr_ptr]     <= in_pc_plus4;
            exp_test[wr_ptr]     <= cur_test;
            exp_cycle[wr_ptr]    <= cycle_cnt;
            exp_lat[wr_ptr]      <= lat_phase;
            wr_ptr               <= wr_ptr + 10'd1;
        end
        if (out_xfer) begin
            rd_ptr <= rd_ptr + 10'd1;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    // Back-pressure from a pattern drawn once at start
    always @(posedge clk_i) begin
        #1;
        out_ready_i = ready_random ? ready_pattern[cycle_cnt[11:0]] : 1'b1;
    end

    assert property (@(posedge clk_i) !arst_n_i |-> (!out_valid_o && in_ready_o && !mispredict_o))
    else report_failure("output valid or input not ready during reset");

    assert property (@(posedge clk_i) disable iff (!arst_n_i) out_xfer |-> (rd_ptr != wr_ptr))
    else report_failure("output transfer with no item in flight");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_xfer |-> (taken_o == exp_taken[rd_ptr]))
    else report_mismatch("taken", exp_test[$sampled(rd_ptr)],
                         {31'b0, exp_taken[$sampled(rd_ptr)]}, {31'b0, $sampled(taken_o)});

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_xfer |-> (mispredict_o == exp_misp[rd_ptr]))
    else report_mismatch("mispredict", exp_test[$sampled(rd_ptr)],
                         {31'b0, exp_misp[$sampled(rd_ptr)]}, {31'b0, $sampled(mispredict_o)});

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_xfer |-> (redirect_pc_o == exp_redirect[rd_ptr]))
    else report_mismatch("redirect_pc", exp_test[$sampled(rd_ptr)],
                         exp_redirect[$sampled(rd_ptr)], $sampled(redirect_pc_o));

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_xfer |-> (link_addr_o == exp_link[rd_ptr]))
    else report_mismatch("link_addr", exp_test[$sampled(rd_ptr)],
                         exp_link[$sampled(rd_ptr)], $sampled(link_addr_o));

    // Three stages, one cycle each
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (out_xfer && exp_lat[rd_ptr]) |-> (cycle_cnt - exp_cycle[rd_ptr] == 3))
    else report_mismatch("latency", 5, 32'd3,
                         $sampled(cycle_cnt) - exp_cycle[$sampled(rd_ptr)]);

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (lat_phase && in_valid_i) |-> in_ready_o)
    else report_failure("input stalled while out_ready_i was held high");

    task automatic send_item(input branch_op_e op, input logic [2:0] f3, input logic jalr,
                             input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                             input logic [XLEN-1:0] pc, input logic [XLEN-1:0] imm,
                             input logic pt, input logic [XLEN-1:0] ptgt);
        logic ready_seen;
        in_valid_i    = 1'b1;
        branch_op_i   = op;
        funct3_i      = f3;
        jalr_i        = jalr;
        rs1_i         = a;
        rs2_i         = b;
        pc_i          = pc;
        imm_i         = imm;
        pred_taken_i  = pt;
        pred_target_i = ptgt;
        ready_seen    = 1'b0;
        while (!ready_seen) begin
            @(negedge clk_i);
            ready_seen = in_ready_o; // Stable mid-cycle
            @(posedge clk_i);
            #1;
        end
        in_valid_i = 1'b0;
        items_sent++;
    endtask

    task automatic wait_drain();
        while (rd_ptr != wr_ptr) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
    endtask

    initial begin
        logic [XLEN-1:0] op_a  [0:7];
        logic [XLEN-1:0] op_b  [0:7];
        logic [2:0]      conds [0:7];
        logic [31:0]     rnd;
        logic [XLEN-1:0] ra;
        logic [XLEN-1:0] rb;
        logic [XLEN-1:0] rpc;
        logic [XLEN-1:0] rimm;
        logic [XLEN-1:0] rtgt;
        logic [2:0]      cidx;
        branch_op_e      rop;
        logic            rjalr;

        arst_n_i      = 1'b1;
        in_valid_i    = 1'b0;
        rs1_i         = '0;
        rs2_i         = '0;
        pc_i          = '0;
        imm_i         = '0;
        funct3_i      = 3'b000;
        branch_op_i   = BR_NONE;
        jalr_i        = 1'b0;
        pred_taken_i  = 1'b0;
        pred_target_i = '0;
        for (int i = 0; i < 4096; i++) begin
            rnd = $random(seed);
            ready_pattern[i[11:0]] = rnd[0]; // About half the cycles stalled
        end
        conds[0] = BEQ;
        conds[1] = BNE;
        conds[2] = BLT;
        conds[3] = BGE;
        conds[4] = BLTU;
        conds[5] = BGEU;
        op_a[0] = 32'd5;         op_b[0] = 32'd5;         // Equal
        op_a[1] = 32'hffff_fffd; op_b[1] = 32'd2;         // Signed less, unsigned greater
        op_a[2] = 32'd2;         op_b[2] = 32'd7;         // Less both ways
        op_a[3] = 32'h8000_0000; op_b[3] = 32'd1;         // Overflow on subtract
        op_a[4] = 32'd1;         op_b[4] = 32'h8000_0000; // Overflow the other way

        #1;
        arst_n_i = 1'b0;
        repeat (3) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        @(posedge clk_i);
        #1;

        cur_test = 1;
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 5; p++) begin
                send_item(BR_COND, conds[c[2:0]], 1'b0, op_a[p[2:0]], op_b[p[2:0]],
                          32'h0000_1000 + 32'(c * 64 + p * 4), 32'h0000_0040, 1'b0, '0);
            end
        end
        wait_drain();

        cur_test = 2;
        send_item(BR_JUMP, 3'b000, 1'b0, '0, '0, 32'h2000, 32'h100, 1'b1, 32'h2100); // JAL
        send_item(BR_JUMP, 3'b000, 1'b0, '0, '0, 32'h2004, 32'hffff_fff0, 1'b0, '0);
        send_item(BR_JUMP, 3'b000, 1'b1, 32'h3001, '0, 32'h2008, 32'h4, 1'b1, 32'h3004);
        send_item(BR_JUMP, 3'b000, 1'b1, 32'h4000, '0, 32'h200c, 32'hffff_ffff, 1'b1,
                  32'h3fff);                                 // Odd prediction, bit 0 dropped
        send_item(BR_NONE, 3'b000, 1'b0, 32'd9, 32'd9, 32'h2010, 32'h80, 1'b0, '0);
        send_item(BR_NONE, 3'b000, 1'b0, 32'd9, 32'd9, 32'h2014, 32'h80, 1'b1, 32'h2094);
        wait_drain();

        cur_test = 3;
        send_item(BR_COND, BEQ, 1'b0, 32'd3, 32'd3, 32'h5000, 32'h20, 1'b0, '0);
        send_item(BR_COND, BNE, 1'b0, 32'd3, 32'd3, 32'h5004, 32'h20, 1'b1, 32'h5024);
        send_item(BR_COND, BLT, 1'b0, 32'd1, 32'd2, 32'h5008, 32'h20, 1'b1, 32'h5028);
        send_item(BR_COND, BLT, 1'b0, 32'd1, 32'd2, 32'h500c, 32'h20, 1'b1, 32'h5030);
        send_item(BR_COND, BGEU, 1'b0, 32'd1, 32'd2, 32'h5010, 32'h20, 1'b0, 32'hdead_beec);
        send_item(BR_COND, BLTU, 1'b0, 32'd1, 32'd2, 32'h5014, 32'h20, 1'b1, 32'h5038);
        wait_drain();

        cur_test = 4;
        ready_random = 1'b1;
        for (int n = 0; n < 300; n++) begin
            rnd   = $random(seed);
            rop   = (rnd[1:0] == 2'b00) ? BR_NONE : ((rnd[1:0] == 2'b01) ? BR_JUMP : BR_COND);
            rjalr = (rop == BR_JUMP) && rnd[2];
            cidx  = 3'({rnd[31:8]} % 6);
            ra    = $random(seed);
            rb    = rnd[3] ? ra : $random(seed); // Force equal operands now and then
            rpc   = $random(seed);
            rpc[1:0] = 2'b00;
            rimm  = $random(seed);
            rtgt  = ref_target(rjalr, ra, rpc, rimm);
            if (rnd[4]) begin
                rtgt = rtgt ^ 32'h10; // Wrong target prediction
            end
            send_item(rop, conds[cidx], rjalr, ra, rb, rpc, rimm, rnd[5], rtgt);
            if (rnd[6] && rnd[7]) begin
                @(posedge clk_i); // Idle gap
                #1;
            end
        end
        wait_drain();
        ready_random = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;

        cur_test  = 5;
        lat_phase = 1'b1;
        for (int n = 0; n < 20; n++) begin
            send_item(BR_COND, BNE, 1'b0, 32'(n), 32'd7, 32'h8000 + 32'(n * 4), 32'h10,
                      1'b1, 32'h8010 + 32'(n * 4));
        end
        lat_phase = 1'b0;
        wait_drain();

        if (rd_ptr == wr_ptr && int'(wr_ptr) == items_sent) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("item count off: %0d sent, %0d accepted, %0d checked", items_sent,
                     wr_ptr, rd_ptr);
            $display("tests failed");
            $fatal(1, "items lost or duplicated");
        end
    end

endmodule
